/* hdl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int REG_W     = 5;
    localparam int XLEN      = 32;
    localparam int MEM_DEPTH = 256;                 // Words per memory
    localparam int MEM_AW    = $clog2(MEM_DEPTH);   // Word index width

    localparam logic [REG_W-1:0] REG_ZERO = '0;     // Hardwired zero register

    // Primary opcode in instr[31:26]
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        BEQ    = 6'h04,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // R-type function field in instr[5:0]
    typedef enum logic [5:0] {
        JR  = 6'h08,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

endpackage

/* hdl/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // Operation of the EX stage ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4     // Signed set-less-than
    } alu_op_e;

    // Where an ALU operand comes from in EX
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,  // Value read in ID
        FWD_EXMEM = 2'd1,  // Result one stage ahead
        FWD_MEMWB = 2'd2   // Result two stages ahead
    } fwd_sel_e;

endpackage

/* hdl/hazard_detection.sv */
module hazard_detection (
    input  logic                          id_ex_mem_read,
    input  logic [cpu_isa_pkg::REG_W-1:0] id_ex_rt,
    input  logic [cpu_isa_pkg::REG_W-1:0] if_id_rs,
    input  logic [cpu_isa_pkg::REG_W-1:0] if_id_rt,
    input  logic                          ex_mem_reg_write,
    input  logic [cpu_isa_pkg::REG_W-1:0] ex_mem_rd,
    input  logic                          mem_wb_reg_write,
    input  logic [cpu_isa_pkg::REG_W-1:0] mem_wb_rd,
    input  logic                          id_is_branch,
    input  logic                          id_is_jr,
    input  logic                          id_is_jump,
    input  logic                          mem_branch_taken,
    output logic                          pc_write,
    output logic                          if_id_write,
    output logic                          control_sel,
    output logic                          if_flush,
    output logic                          id_flush
);
    import cpu_isa_pkg::*;

    logic dep_exmem_rs;
    logic dep_exmem_rt;
    logic dep_memwb_rs;
    logic dep_memwb_rt;
    logic load_use;
    logic branch_dep;
    logic jr_dep;
    logic stall;
    logic redirect;

    // Sources of the ID instruction still on their way to the register file
    assign dep_exmem_rs = ex_mem_reg_write && ex_mem_rd != REG_ZERO && ex_mem_rd == if_id_rs;
    assign dep_exmem_rt = ex_mem_reg_write && ex_mem_rd != REG_ZERO && ex_mem_rd == if_id_rt;
    assign dep_memwb_rs = mem_wb_reg_write && mem_wb_rd != REG_ZERO && mem_wb_rd == if_id_rs;
    assign dep_memwb_rt = mem_wb_reg_write && mem_wb_rd != REG_ZERO && mem_wb_rd == if_id_rt;

    assign load_use = id_ex_mem_read && id_ex_rt != REG_ZERO
                      && (id_ex_rt == if_id_rs || id_ex_rt == if_id_rt);

    assign branch_dep = id_is_branch
                        && (dep_exmem_rs || dep_exmem_rt || dep_memwb_rs || dep_memwb_rt);
    assign jr_dep     = id_is_jr && (dep_exmem_rs || dep_memwb_rs);   // jr only reads rs

    assign stall = load_use || branch_dep || jr_dep;

    // A jr redirects from ID once its target register has settled
    assign redirect = mem_branch_taken || id_is_jump || (id_is_jr && !stall);

    always_comb begin
        pc_write    = 1'b1;
        if_id_write = 1'b1;
        control_sel = 1'b1;     // Decoded controls go into ID/EX
        if_flush    = 1'b0;
        id_flush    = 1'b0;
        if (redirect) begin
            if_flush = 1'b1;
            id_flush = mem_branch_taken;   // Only a branch in MEM has a wrong-path ID entry
        end else if (stall) begin
            pc_write    = 1'b0;
            if_id_write = 1'b0;
            control_sel = 1'b0;            // Bubble into ID/EX
        end
    end

endmodule

/* hdl/forwarding_unit.sv */
module forwarding_unit (
    input  logic [cpu_isa_pkg::REG_W-1:0] id_ex_rs,
    input  logic [cpu_isa_pkg::REG_W-1:0] id_ex_rt,
    input  logic                          ex_mem_reg_write,
    input  logic [cpu_isa_pkg::REG_W-1:0] ex_mem_rd,
    input  logic                          mem_wb_reg_write,
    input  logic [cpu_isa_pkg::REG_W-1:0] mem_wb_rd,
    output cpu_ctrl_pkg::fwd_sel_e        fwd_a,
    output cpu_ctrl_pkg::fwd_sel_e        fwd_b
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    // Youngest producer wins, r0 is never forwarded
    function automatic fwd_sel_e pick(input logic [REG_W-1:0] src);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (ex_mem_reg_write && ex_mem_rd != REG_ZERO && ex_mem_rd == src) begin
            sel = FWD_EXMEM;
        end else if (mem_wb_reg_write && mem_wb_rd != REG_ZERO && mem_wb_rd == src) begin
            sel = FWD_MEMWB;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick(id_ex_rs);
        fwd_b = pick(id_ex_rt);
    end

endmodule

/* hdl/control_decoder.sv */
module control_decoder (
    input  logic [31:0]           instr,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  alu_src,
    output logic                  reg_dst,
    output logic                  is_branch,
    output logic                  is_jump,
    output logic                  is_jr,
    output cpu_ctrl_pkg::alu_op_e alu_op
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        reg_dst    = 1'b0;
        is_branch  = 1'b0;
        is_jump    = 1'b0;
        is_jr      = 1'b0;
        alu_op     = ALU_ADD;
        case (opcode)
            R_TYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    ADD: alu_op = ALU_ADD;
                    SUB: alu_op = ALU_SUB;
                    AND: alu_op = ALU_AND;
                    OR:  alu_op = ALU_OR;
                    SLT: alu_op = ALU_SLT;
                    JR: begin
                        reg_write = 1'b0;
                        is_jr     = 1'b1;
                    end
                    default: reg_write = 1'b0;   // Unknown funct
                endcase
            end
            ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            LW: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
            end
            SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            BEQ:     is_branch = 1'b1;   // Compare is done on the forwarded operands
            J:       is_jump   = 1'b1;
            default: ;                   // Unknown opcode runs as a no-op
        endcase
    end

endmodule

/* hdl/register_file.sv */
module register_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cpu_isa_pkg::REG_W-1:0] ra1,
    input  logic [cpu_isa_pkg::REG_W-1:0] ra2,
    output logic [cpu_isa_pkg::XLEN-1:0]  rd1,
    output logic [cpu_isa_pkg::XLEN-1:0]  rd2,
    input  logic                          we,
    input  logic [cpu_isa_pkg::REG_W-1:0] wa,
    input  logic [cpu_isa_pkg::XLEN-1:0]  wd
);
    import cpu_isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != REG_ZERO) begin
            regs[wa] <= wd;
        end
    end

    // Write in the same cycle is passed straight to the reader
    assign rd1 = (ra1 == REG_ZERO)     ? '0 :
                 (we && wa == ra1)     ? wd : regs[ra1];
    assign rd2 = (ra2 == REG_ZERO)     ? '0 :
                 (we && wa == ra2)     ? wd : regs[ra2];

endmodule

/* hdl/word_memory.sv */
module word_memory #(
    parameter int  DEPTH = 256,
    parameter int  WIDTH = 32,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             we,
    input  logic [AW-1:0]    waddr,
    input  logic [WIDTH-1:0] wdata,
    input  logic [AW-1:0]    raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];   // Read in the same cycle

endmodule

/* hdl/pipeline_core.sv */
module pipeline_core (
    input  logic                           clk,
    input  logic                           rst,
    output logic [cpu_isa_pkg::MEM_AW-1:0] imem_addr,
    input  logic [cpu_isa_pkg::XLEN-1:0]   imem_rdata,
    output logic [cpu_isa_pkg::MEM_AW-1:0] dmem_addr,
    output logic [cpu_isa_pkg::XLEN-1:0]   dmem_wdata,
    output logic                           dmem_we,
    input  logic [cpu_isa_pkg::XLEN-1:0]   dmem_rdata,
    output logic                           wb_valid,
    output logic [cpu_isa_pkg::REG_W-1:0]  wb_rd,
    output logic [cpu_isa_pkg::XLEN-1:0]   wb_data,
    output logic                           st_valid,
    output logic [cpu_isa_pkg::XLEN-1:0]   st_addr,
    output logic [cpu_isa_pkg::XLEN-1:0]   st_data
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  pc_plus4;
    logic             if_id_valid;
    logic [XLEN-1:0]  if_id_instr;
    logic [XLEN-1:0]  if_id_pc4;

    logic             d_reg_write;
    logic             d_mem_read;
    logic             d_mem_write;
    logic             d_mem_to_reg;
    logic             d_alu_src;
    logic             d_reg_dst;
    logic             d_is_branch;
    logic             d_is_jump;
    logic             d_is_jr;
    alu_op_e          d_alu_op;
    logic [REG_W-1:0] id_rs;
    logic [REG_W-1:0] id_rt;
    logic [REG_W-1:0] id_dest;
    logic [XLEN-1:0]  id_imm;
    logic [XLEN-1:0]  rf_rd1;
    logic [XLEN-1:0]  rf_rd2;
    logic [XLEN-1:0]  jump_target;
    logic             id_is_branch;
    logic             id_is_jump;
    logic             id_is_jr;
    logic             hz_ex_read;
    logic             pc_write;
    logic             if_id_write;
    logic             control_sel;
    logic             if_flush;
    logic             id_flush;

    logic             id_ex_valid;
    logic             id_ex_reg_write;
    logic             id_ex_mem_read;
    logic             id_ex_mem_write;
    logic             id_ex_mem_to_reg;
    logic             id_ex_alu_src;
    logic             id_ex_is_branch;
    alu_op_e          id_ex_alu_op;
    logic [XLEN-1:0]  id_ex_pc4;
    logic [XLEN-1:0]  id_ex_rd1;
    logic [XLEN-1:0]  id_ex_rd2;
    logic [XLEN-1:0]  id_ex_imm;
    logic [REG_W-1:0] id_ex_rs;
    logic [REG_W-1:0] id_ex_rt;
    logic [REG_W-1:0] id_ex_rd;

    fwd_sel_e         fwd_a;
    fwd_sel_e         fwd_b;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  alu_b;
    logic [XLEN-1:0]  alu_y;

    logic             ex_mem_valid;
    logic             ex_mem_reg_write;
    logic             ex_mem_mem_write;
    logic             ex_mem_mem_to_reg;
    logic             ex_mem_taken;
    logic [XLEN-1:0]  ex_mem_target;
    logic [XLEN-1:0]  ex_mem_alu;
    logic [XLEN-1:0]  ex_mem_store;
    logic [REG_W-1:0] ex_mem_rd;
    logic             ex_mem_wr_en;
    logic             mem_branch_taken;

    logic             mem_wb_valid;
    logic             mem_wb_reg_write;
    logic             mem_wb_mem_to_reg;
    logic [XLEN-1:0]  mem_wb_alu;
    logic [XLEN-1:0]  mem_wb_load;
    logic [REG_W-1:0] mem_wb_rd;
    logic             mem_wb_wr_en;

    assign pc_plus4  = pc + 32'd4;
    assign imem_addr = pc[MEM_AW+1:2];

    control_decoder u_decoder (
        .instr      (if_id_instr),
        .reg_write  (d_reg_write),
        .mem_read   (d_mem_read),
        .mem_write  (d_mem_write),
        .mem_to_reg (d_mem_to_reg),
        .alu_src    (d_alu_src),
        .reg_dst    (d_reg_dst),
        .is_branch  (d_is_branch),
        .is_jump    (d_is_jump),
        .is_jr      (d_is_jr),
        .alu_op     (d_alu_op)
    );

    assign id_rs   = if_id_instr[25:21];
    assign id_rt   = if_id_instr[20:16];
    assign id_dest = d_reg_dst ? if_id_instr[15:11] : id_rt;
    assign id_imm  = {{(XLEN-16){if_id_instr[15]}}, if_id_instr[15:0]};

    register_file u_regs (
        .clk (clk),
        .rst (rst),
        .ra1 (id_rs),
        .ra2 (id_rt),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2),
        .we  (mem_wb_wr_en),
        .wa  (mem_wb_rd),
        .wd  (wb_data)
    );

    assign id_is_branch = if_id_valid && d_is_branch;
    assign id_is_jump   = if_id_valid && d_is_jump;
    assign id_is_jr     = if_id_valid && d_is_jr;
    assign jump_target  = d_is_jr ? rf_rd1 : {if_id_pc4[31:28], if_id_instr[25:0], 2'b00};

    // jr takes its target from the register file, so an ALU producer in EX holds it too
    assign hz_ex_read = id_ex_valid && if_id_valid
                        && (id_ex_mem_read || (id_ex_reg_write && d_is_jr));

    hazard_detection u_hazard (
        .id_ex_mem_read   (hz_ex_read),
        .id_ex_rt         (id_ex_rd),          // Destination of the EX entry, rt for a load
        .if_id_rs         (id_rs),
        .if_id_rt         (id_rt),
        .ex_mem_reg_write (ex_mem_wr_en),
        .ex_mem_rd        (ex_mem_rd),
        .mem_wb_reg_write (mem_wb_wr_en),
        .mem_wb_rd        (mem_wb_rd),
        .id_is_branch     (id_is_branch),
        .id_is_jr         (id_is_jr),
        .id_is_jump       (id_is_jump),
        .mem_branch_taken (mem_branch_taken),
        .pc_write         (pc_write),
        .if_id_write      (if_id_write),
        .control_sel      (control_sel),
        .if_flush         (if_flush),
        .id_flush         (id_flush)
    );

    forwarding_unit u_fwd (
        .id_ex_rs         (id_ex_rs),
        .id_ex_rt         (id_ex_rt),
        .ex_mem_reg_write (ex_mem_wr_en),
        .ex_mem_rd        (ex_mem_rd),
        .mem_wb_reg_write (mem_wb_wr_en),
        .mem_wb_rd        (mem_wb_rd),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b)
    );

    always_comb begin
        case (fwd_a)
            FWD_EXMEM: op_a = ex_mem_alu;
            FWD_MEMWB: op_a = wb_data;
            default:   op_a = id_ex_rd1;
        endcase
        case (fwd_b)
            FWD_EXMEM: op_b = ex_mem_alu;
            FWD_MEMWB: op_b = wb_data;
            default:   op_b = id_ex_rd2;
        endcase
    end

    assign alu_b = id_ex_alu_src ? id_ex_imm : op_b;

    always_comb begin
        case (id_ex_alu_op)
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_y = op_a + alu_b;
        endcase
    end

    assign ex_mem_wr_en     = ex_mem_valid && ex_mem_reg_write;
    assign mem_branch_taken = ex_mem_valid && ex_mem_taken;
    assign mem_wb_wr_en     = mem_wb_valid && mem_wb_reg_write;

    // PC and the valid bit of every stage
    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= '0;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            if (mem_branch_taken) begin
                pc <= ex_mem_target;
            end else if (if_flush) begin
                pc <= jump_target;             // j or jr resolved in ID
            end else if (pc_write) begin
                pc <= pc_plus4;
            end
            if (if_flush) begin
                if_id_valid <= 1'b0;
            end else if (if_id_write) begin
                if_id_valid <= 1'b1;
            end
            id_ex_valid  <= if_id_valid && control_sel && !id_flush;
            ex_mem_valid <= id_ex_valid && !mem_branch_taken;   // Squash the entry in EX
            mem_wb_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_write) begin
            if_id_instr <= imem_rdata;
            if_id_pc4   <= pc_plus4;
        end
        id_ex_reg_write   <= d_reg_write;
        id_ex_mem_read    <= d_mem_read;
        id_ex_mem_write   <= d_mem_write;
        id_ex_mem_to_reg  <= d_mem_to_reg;
        id_ex_alu_src     <= d_alu_src;
        id_ex_is_branch   <= d_is_branch;
        id_ex_alu_op      <= d_alu_op;
        id_ex_pc4         <= if_id_pc4;
        id_ex_rd1         <= rf_rd1;
        id_ex_rd2         <= rf_rd2;
        id_ex_imm         <= id_imm;
        id_ex_rs          <= id_rs;
        id_ex_rt          <= id_rt;
        id_ex_rd          <= id_dest;
        ex_mem_reg_write  <= id_ex_reg_write;
        ex_mem_mem_write  <= id_ex_mem_write;
        ex_mem_mem_to_reg <= id_ex_mem_to_reg;
        ex_mem_taken      <= id_ex_is_branch && op_a == op_b;   // Acted on one stage later
        ex_mem_target     <= id_ex_pc4 + {id_ex_imm[XLEN-3:0], 2'b00};
        ex_mem_alu        <= alu_y;
        ex_mem_store      <= op_b;
        ex_mem_rd         <= id_ex_rd;
        mem_wb_reg_write  <= ex_mem_reg_write;
        mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
        mem_wb_alu        <= ex_mem_alu;
        mem_wb_load       <= dmem_rdata;
        mem_wb_rd         <= ex_mem_rd;
    end

    // Data memory port and store trace from MEM
    assign st_valid   = ex_mem_valid && ex_mem_mem_write;
    assign st_addr    = ex_mem_alu;
    assign st_data    = ex_mem_store;
    assign dmem_addr  = ex_mem_alu[MEM_AW+1:2];
    assign dmem_wdata = ex_mem_store;
    assign dmem_we    = st_valid;

    assign wb_data  = mem_wb_mem_to_reg ? mem_wb_load : mem_wb_alu;
    assign wb_rd    = mem_wb_rd;
    assign wb_valid = mem_wb_wr_en && mem_wb_rd != REG_ZERO;   // r0 writes stay silent

endmodule

/* hdl/mips_pipeline_top.sv */
module mips_pipeline_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           imem_we,
    input  logic [cpu_isa_pkg::MEM_AW-1:0] imem_addr,
    input  logic [cpu_isa_pkg::XLEN-1:0]   imem_data,
    output logic                           wb_valid,
    output logic [cpu_isa_pkg::REG_W-1:0]  wb_rd,
    output logic [cpu_isa_pkg::XLEN-1:0]   wb_data,
    output logic                           st_valid,
    output logic [cpu_isa_pkg::XLEN-1:0]   st_addr,
    output logic [cpu_isa_pkg::XLEN-1:0]   st_data
);
    import cpu_isa_pkg::*;

    logic [MEM_AW-1:0] fetch_addr;
    logic [XLEN-1:0]   fetch_word;
    logic [MEM_AW-1:0] dmem_addr;
    logic [XLEN-1:0]   dmem_wdata;
    logic              dmem_we;
    logic [XLEN-1:0]   dmem_rdata;

    pipeline_core u_core (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (fetch_addr),
        .imem_rdata (fetch_word),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data)
    );

    // Program store, written only by the loader
    word_memory #(.DEPTH(MEM_DEPTH), .WIDTH(XLEN)) imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_data),
        .raddr (fetch_addr),
        .rdata (fetch_word)
    );

    word_memory #(.DEPTH(MEM_DEPTH), .WIDTH(XLEN)) dmem (
        .clk   (clk),
        .we    (dmem_we),
        .waddr (dmem_addr),
        .wdata (dmem_wdata),
        .raddr (dmem_addr),
        .rdata (dmem_rdata)
    );

endmodule

/* verif/mips_pipeline_checker.sv */
module mips_pipeline_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          id_ex_mem_read,
    input logic [cpu_isa_pkg::REG_W-1:0] id_ex_rt,
    input logic [cpu_isa_pkg::REG_W-1:0] if_id_rs,
    input logic [cpu_isa_pkg::REG_W-1:0] if_id_rt,
    input logic                          pc_write,
    input logic                          if_id_write,
    input logic                          control_sel,
    input logic                          if_flush,
    input logic                          id_flush
);
    import cpu_isa_pkg::*;

    int   error_count = 0;   // Read by the testbench monitor
    logic load_use;
    logic stall;

    assign load_use = id_ex_mem_read && id_ex_rt != REG_ZERO
                      && (id_ex_rt == if_id_rs || id_ex_rt == if_id_rt);
    assign stall    = !pc_write || !if_id_write || !control_sel;

    flush_moves_pc: assert property (@(posedge clk) disable iff (rst) if_flush |-> pc_write)
        else begin
            $error("if_flush raised while the PC is held");
            error_count++;
        end

    id_flush_needs_if_flush: assert property (@(posedge clk) disable iff (rst)
                                              id_flush |-> if_flush)
        else begin
            $error("id_flush raised without if_flush");
            error_count++;
        end

    // Redirect wins, so both together is a priority bug
    no_stall_with_flush: assert property (@(posedge clk) disable iff (rst)
                                          !(stall && (if_flush || id_flush)))
        else begin
            $error("stall and flush asserted in the same cycle");
            error_count++;
        end

    load_use_bubble: assert property (@(posedge clk) disable iff (rst)
                                      (load_use && !if_flush) |-> !control_sel)
        else begin
            $error("load-use on a nonzero register left control_sel high");
            error_count++;
        end

endmodule

// The hazard unit has no clock of its own, so the checker sits in the core next to it
bind pipeline_core mips_pipeline_checker hazard_checker (
    .clk            (clk),
    .rst            (rst),
    .id_ex_mem_read (hz_ex_read),
    .id_ex_rt       (id_ex_rd),
    .if_id_rs       (id_rs),
    .if_id_rt       (id_rt),
    .pc_write       (pc_write),
    .if_id_write    (if_id_write),
    .control_sel    (control_sel),
    .if_flush       (if_flush),
    .id_flush       (id_flush)
);

/* verif/mips_pipeline_tb.sv */
module mips_pipeline_tb;
    import cpu_isa_pkg::*;

    localparam int          PROG_LEN    = 30;
    localparam int          CYCLE_LIMIT = 8 * PROG_LEN + 20;
    localparam logic [31:0] SEED        = 32'd17836;

    logic              clk;
    logic              rst;
    logic              imem_we;
    logic [MEM_AW-1:0] imem_addr;
    logic [XLEN-1:0]   imem_data;
    logic              wb_valid;
    logic [REG_W-1:0]  wb_rd;
    logic [XLEN-1:0]   wb_data;
    logic              st_valid;
    logic [XLEN-1:0]   st_addr;
    logic [XLEN-1:0]   st_data;

    logic [XLEN-1:0]   prog [PROG_LEN];   // One encoded instruction per word
    logic [REG_W-1:0]  exp_wb_rd [$];
    logic [XLEN-1:0]   exp_wb_data [$];
    logic [XLEN-1:0]   exp_st_addr [$];
    logic [XLEN-1:0]   exp_st_data [$];
    int                n_wb;
    int                n_st;
    int                wb_idx = 0;
    int                st_idx = 0;
    int                cycles = 0;

    mips_pipeline_top UUT (
        .clk       (clk),
        .rst       (rst),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [XLEN-1:0] sext16(input logic [15:0] imm);
        return {{(XLEN-16){imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] rtype_word(input funct_e f, input int rs, input int rt,
                                               input int rd);
        return {R_TYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, f};
    endfunction

    function automatic logic [31:0] itype_word(input opcode_e op, input int rs, input int rt,
                                               input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [25:0] index);
        return {J, index};   // Target is a word index
    endfunction

    task automatic wb_entry(input int rd, input logic [XLEN-1:0] data);
        exp_wb_rd.push_back(rd[REG_W-1:0]);
        exp_wb_data.push_back(data);
    endtask

    task automatic store_entry(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(data);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic build_tables();
        logic [31:0]     rng;
        logic [15:0]     i0;
        logic [15:0]     i1;
        logic [15:0]     i2;
        logic [15:0]     i3;
        logic [XLEN-1:0] r1;
        logic [XLEN-1:0] r2;
        logic [XLEN-1:0] r3;
        logic [XLEN-1:0] r4;
        logic [XLEN-1:0] r5;
        logic [XLEN-1:0] r6;
        logic [XLEN-1:0] r13;
        rng = xorshift32(SEED);
        i0  = rng[15:0];
        rng = xorshift32(rng);
        i1  = rng[15:0];
        rng = xorshift32(rng);
        i2  = rng[15:0];
        rng = xorshift32(rng);
        i3  = rng[15:0];
        if (i1 == i0) begin
            i1 = ~i0;   // Keeps the second beq not taken
        end

        prog[0]  = itype_word(ADDI, 0, 1, i0);
        prog[1]  = itype_word(ADDI, 0, 2, i1);
        prog[2]  = rtype_word(ADD, 1, 2, 3);        // Operands from MEM/WB and EX/MEM
        prog[3]  = rtype_word(SUB, 3, 1, 4);
        prog[4]  = rtype_word(AND, 3, 4, 5);
        prog[5]  = rtype_word(OR, 5, 2, 6);
        prog[6]  = rtype_word(SLT, 1, 3, 7);
        prog[7]  = itype_word(SW, 0, 3, 16'd0);
        prog[8]  = itype_word(SW, 0, 6, 16'd4);
        prog[9]  = itype_word(LW, 0, 8, 16'd0);
        prog[10] = rtype_word(ADD, 8, 1, 9);        // Load-use stall
        prog[11] = itype_word(ADDI, 1, 0, i2);      // Write to r0 stays silent
        prog[12] = rtype_word(ADD, 0, 1, 10);
        prog[13] = rtype_word(ADD, 1, 1, 11);
        prog[14] = itype_word(BEQ, 10, 1, 16'd3);   // Stalls on r10, then taken to 18
        prog[15] = itype_word(ADDI, 0, 12, 16'd1);
        prog[16] = itype_word(SW, 0, 1, 16'd8);
        prog[17] = itype_word(ADDI, 0, 12, 16'd2);
        prog[18] = itype_word(BEQ, 1, 2, 16'd1);    // Not taken
        prog[19] = itype_word(ADDI, 2, 13, i3);
        prog[20] = jump_word(26'd22);
        prog[21] = itype_word(ADDI, 0, 14, 16'd5);
        prog[22] = itype_word(ADDI, 0, 15, 16'd104);
        prog[23] = rtype_word(JR, 15, 0, 0);        // Lands on word 26
        prog[24] = itype_word(ADDI, 0, 16, 16'd7);
        prog[25] = itype_word(SW, 0, 2, 16'd12);
        prog[26] = itype_word(SW, 0, 13, 16'd12);
        prog[27] = itype_word(LW, 0, 17, 16'd12);
        prog[28] = rtype_word(SUB, 17, 2, 18);
        prog[29] = jump_word(26'd29);               // Park here

        r1  = sext16(i0);
        r2  = sext16(i1);
        r3  = r1 + r2;
        r4  = r3 - r1;
        r5  = r3 & r4;
        r6  = r5 | r2;
        r13 = r2 + sext16(i3);
        wb_entry(1, r1);
        wb_entry(2, r2);
        wb_entry(3, r3);
        wb_entry(4, r4);
        wb_entry(5, r5);
        wb_entry(6, r6);
        wb_entry(7, ($signed(r1) < $signed(r3)) ? 32'd1 : 32'd0);
        wb_entry(8, r3);
        wb_entry(9, r3 + r1);
        wb_entry(10, r1);
        wb_entry(11, r1 + r1);
        wb_entry(13, r13);
        wb_entry(15, 32'd104);
        wb_entry(17, r13);
        wb_entry(18, r13 - r2);
        store_entry(32'd0, r3);
        store_entry(32'd4, r6);
        store_entry(32'd12, r13);
        n_wb = exp_wb_rd.size();
        n_st = exp_st_addr.size();
    endtask

    task automatic check_wb(input logic [REG_W-1:0] rd, input logic [XLEN-1:0] data);
        if (wb_rd !== rd) begin
            abort_run($sformatf("error: wb_rd expected 0x%h got 0x%h", rd, wb_rd));
        end else if (wb_data !== data) begin
            abort_run($sformatf("error: wb_data expected 0x%h got 0x%h", data, wb_data));
        end
    endtask

    task automatic verify_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        if (st_addr !== addr) begin
            abort_run($sformatf("error: st_addr expected 0x%h got 0x%h", addr, st_addr));
        end else if (st_data !== data) begin
            abort_run($sformatf("error: st_data expected 0x%h got 0x%h", data, st_data));
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            cycles = cycles + 1;
            if (cycles > CYCLE_LIMIT) begin
                abort_run($sformatf("timeout after %0d cycles, %0d of %0d results seen",
                                    cycles, wb_idx + st_idx, n_wb + n_st));
            end else if (UUT.u_core.hazard_checker.error_count != 0) begin
                abort_run("a hazard control assertion failed");
            end else begin
                if (wb_valid) begin
                    if (wb_idx >= n_wb) begin
                        abort_run($sformatf("unexpected extra write-back to register %0d",
                                            wb_rd));
                    end else begin
                        check_wb(exp_wb_rd[wb_idx], exp_wb_data[wb_idx]);
                        wb_idx = wb_idx + 1;
                    end
                end
                if (st_valid) begin
                    if (st_idx >= n_st) begin
                        abort_run("unexpected extra store on the store trace");
                    end else begin
                        verify_store(exp_st_addr[st_idx], exp_st_data[st_idx]);
                        st_idx = st_idx + 1;
                    end
                end
            end
        end
    end

    initial begin
        rst       = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_tables();
        // Core stays in reset through the load and two more cycles
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i[MEM_AW-1:0];
            imem_data <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        wait (wb_idx == n_wb && st_idx == n_st);
        repeat (10) @(negedge clk);   // Window for stray events
        @(posedge clk);
        if (UUT.u_core.hazard_checker.error_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("a hazard control assertion failed near the end of the run");
            $display("tests failed");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

/* mips_pipeline.f */
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/hazard_detection.sv
hdl/forwarding_unit.sv
hdl/control_decoder.sv
hdl/register_file.sv
hdl/word_memory.sv
hdl/pipeline_core.sv
hdl/mips_pipeline_top.sv
verif/mips_pipeline_checker.sv
verif/mips_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module mips_pipeline_tb \
    -f mips_pipeline.f \
    -Mdir obj_dir -o sim_mips_pipeline
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past an assertion so the testbench reports it
output=$(./obj_dir/sim_mips_pipeline +verilator+error+limit+10 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass message not found"
exit 1
